// ==== tb.f ====
+incdir+design
design/search_ctrl_pkg.sv
design/mailbox_regs.sv
design/move_ram.sv
design/move_unpacker.sv
design/search_sequencer.sv
design/search_ctrl_top.sv
verification/move_gen_model.sv
verification/tb_search_ctrl.sv

// ==== Bender.yml ====
package:
  name: search_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/search_ctrl_pkg.sv
      - design/mailbox_regs.sv
      - design/move_ram.sv
      - design/move_unpacker.sv
      - design/search_sequencer.sv
      - design/search_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/move_gen_model.sv
      - verification/tb_search_ctrl.sv

// ==== verification/tb_search_ctrl.sv ====
`timescale 1ns/1ps
`include "search_ctrl_consts.svh"

module tb_search_ctrl;

	logic clk, reset, slave_read, slave_write;
	logic lmg_reset, lmg_read, lmg_done, lmg_fifo_empty;
	search_ctrl_pkg::ram_addr_t    slave_address;
	search_ctrl_pkg::word_t        slave_writedata, slave_readdata;
	search_ctrl_pkg::board_state_t board_state;
	search_ctrl_pkg::move_group_t  lmg_fifo_out;
	search_ctrl_pkg::word_t        exp_moves [$]; // expected list from 17 on
	logic [15:0]                   lfsr_state = 16'd2273;

	search_ctrl_top uut (
		.clk(clk), .reset(reset), .slave_address(slave_address), .slave_read(slave_read),
		.slave_write(slave_write), .slave_writedata(slave_writedata),
		.slave_readdata(slave_readdata), .lmg_reset(lmg_reset), .lmg_read(lmg_read),
		.board_state(board_state), .lmg_done(lmg_done), .lmg_fifo_out(lmg_fifo_out),
		.lmg_fifo_empty(lmg_fifo_empty)
	);

	move_gen_model gen (
		.clk(clk), .reset(reset), .lmg_reset(lmg_reset), .lmg_read(lmg_read),
		.lmg_done(lmg_done), .lmg_fifo_out(lmg_fifo_out), .lmg_fifo_empty(lmg_fifo_empty)
	);

	always #5 clk = ~clk; // 10 ns period

	// ==================== helpers
	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [255:0] actual,
			input logic [255:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// fibonacci lfsr on x^16+x^14+x^13+x^11+1 stepped once per bit
	function automatic search_ctrl_pkg::word_t rand_bits(input int n);
		search_ctrl_pkg::word_t r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic bus_write(input search_ctrl_pkg::ram_addr_t addr,
			input search_ctrl_pkg::word_t data);
		@(posedge clk);
		slave_address   <= addr;
		slave_write     <= 1'b1;
		slave_writedata <= data;
		@(posedge clk); // write lands here
		slave_write <= 1'b0;
	endtask

	task automatic bus_read(input search_ctrl_pkg::ram_addr_t addr,
			output search_ctrl_pkg::word_t data);
		@(posedge clk);
		slave_address <= addr;
		slave_read    <= 1'b1;
		@(posedge clk);
		slave_read <= 1'b0;
		@(negedge clk); // readdata valid this cycle only
		data = slave_readdata;
	endtask

	task automatic read_check(input search_ctrl_pkg::ram_addr_t addr,
			input search_ctrl_pkg::word_t expected);
		search_ctrl_pkg::word_t data;
		bus_read(addr, data);
		check($sformatf("slave_readdata[addr %0d]", addr), data, expected);
	endtask

	// slot flag set means invalid
	function automatic search_ctrl_pkg::move_group_t random_group(input logic all_invalid);
		search_ctrl_pkg::move_group_t g;
		search_ctrl_pkg::word_t flag, move;
		for (int s = 0; s < `SC_SLOTS; s++) begin
			flag = all_invalid ? 32'd1 : rand_bits(1);
			move = rand_bits(`SC_MOVE_BITS);
			g[s*`SC_SLOT_BITS +: `SC_SLOT_BITS] = {flag[0], move[`SC_MOVE_BITS-1:0]};
		end
		return g;
	endfunction

	// hand the group to the generator and note its valid moves
	task automatic queue_group(input search_ctrl_pkg::move_group_t g);
		logic [`SC_SLOT_BITS-1:0] slot;
		for (int s = 0; s < `SC_SLOTS; s++) begin
			slot = g[s*`SC_SLOT_BITS +: `SC_SLOT_BITS];
			if (!slot[`SC_SLOT_BITS-1]) begin
				exp_moves.push_back(search_ctrl_pkg::word_t'(slot[`SC_MOVE_BITS-1:0]));
			end
		end
		gen.push_group(g);
	endtask

	task automatic wait_done();
		search_ctrl_pkg::word_t data;
		int polls;
		polls = 0;
		data  = '0;
		while (!data[`SC_DONE_BIT]) begin
			if (polls == 200) begin
				$display("timeout: done bit never set in register 0");
				abort_run();
			end
			bus_read(0, data);
			polls++;
		end
	endtask

	// start edge and two-cycle generator reset before the done poll
	task automatic run_search();
		int waits;
		bus_write(0, 0);
		bus_write(0, 1 << `SC_START_BIT);
		@(negedge clk);
		check("lmg_reset", lmg_reset, 1);
		@(negedge clk);
		check("lmg_reset", lmg_reset, 1);
		@(negedge clk);
		check("lmg_reset", lmg_reset, 0);
		waits = 0;
		while (!lmg_done) begin
			if (waits == 20) begin
				$display("timeout: generator never raised lmg_done");
				abort_run();
			end
			@(negedge clk);
			waits++;
		end
		check("lmg_read", lmg_read, 0);
		@(negedge clk);
		check("lmg_read", lmg_read, 1); // one cycle after done first seen
		@(negedge clk);
		check("lmg_read", lmg_read, 0);
		read_check(0, 1 << `SC_START_BIT); // done still low
		wait_done();
	endtask

	task automatic verify_list();
		read_check(`SC_COUNT_ADDR, exp_moves.size());
		foreach (exp_moves[i]) begin
			read_check(`SC_LIST_BASE + i, exp_moves[i]);
		end
		read_check(`SC_LIST_BASE + exp_moves.size(), 0); // terminator
		read_check(0, (1 << `SC_START_BIT) | (1 << `SC_DONE_BIT));
	endtask

	// ==================== tests
	task automatic ram_readback();
		search_ctrl_pkg::ram_addr_t addr;
		search_ctrl_pkg::word_t data;
		read_check(0, 0); // control word after reset
		repeat (6) begin
			addr = `SC_LIST_BASE + rand_bits(14);
			data = rand_bits(32);
			bus_write(addr, data);
			read_check(addr, data);
		end
	endtask

	task automatic board_regs_readback();
		search_ctrl_pkg::word_t w [`SC_BOARD_REGS];
		search_ctrl_pkg::board_state_t exp_board;
		for (int i = 0; i < `SC_BOARD_REGS; i++) begin
			w[i] = rand_bits(32);
			bus_write(`SC_BOARD_FIRST_REG + i, w[i]);
		end
		for (int i = 0; i < `SC_BOARD_REGS; i++) begin
			read_check(`SC_BOARD_FIRST_REG + i, w[i]);
			exp_board[i*`SC_DATA_WIDTH +: `SC_DATA_WIDTH] = w[i]; // reg 2 lowest
		end
		check("board_state", board_state, exp_board);
	endtask

	task automatic empty_search();
		exp_moves.delete();
		queue_group(random_group(1'b1)); // nothing to store
		run_search();
		verify_list();
	endtask

	task automatic single_group_search();
		exp_moves.delete();
		// slots listed 7 down to 0 with valid moves in 0, 2, 3 and 6
		queue_group({1'b1, 18'h15555, 1'b0, 18'h10001, 1'b1, 18'h00000, 1'b1, 18'h2ffff,
			1'b0, 18'h2a5a5, 1'b0, 18'h3ffff, 1'b1, 18'h00abc, 1'b0, 18'h00123});
		run_search();
		verify_list();
	endtask

	task automatic three_group_search();
		exp_moves.delete();
		queue_group(random_group(1'b0));
		queue_group(random_group(1'b1)); // all invalid in the middle
		queue_group(random_group(1'b0));
		run_search();
		verify_list();
	endtask

	task automatic restart_search();
		search_ctrl_pkg::move_group_t g;
		bus_write(0, 1 << `SC_DONE_BIT); // start cleared while the host sets done
		read_check(0, 0); // done dropped because start is low
		exp_moves.delete();
		g = '1; // every slot invalid
		g[0 +: `SC_SLOT_BITS] = {1'b0, 18'h01111};
		g[`SC_SLOT_BITS +: `SC_SLOT_BITS] = {1'b0, 18'h02222};
		queue_group(g); // short list over the longer one
		run_search();
		verify_list();
	endtask

	// ==================== main
	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		slave_address   = '0;
		slave_read      = 1'b0;
		slave_write     = 1'b0;
		slave_writedata = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		ram_readback();
		board_regs_readback();
		empty_search();
		single_group_search();
		three_group_search();
		restart_search();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== verification/move_gen_model.sv ====
`timescale 1ns/1ps
`include "search_ctrl_consts.svh"

// behavioral legal-move generator that plays back queued fifo groups
module move_gen_model (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         lmg_reset,
	input  logic                         lmg_read,
	output logic                         lmg_done,
	output search_ctrl_pkg::move_group_t lmg_fifo_out,
	output logic                         lmg_fifo_empty
);

	search_ctrl_pkg::move_group_t groups [$]; // fifo contents with the oldest first
	int unsigned                  delay;      // cycles until done rises

	// testbench loads the fifo before a search
	task push_group(input search_ctrl_pkg::move_group_t g);
		groups.push_back(g);
	endtask

	initial begin
		lmg_done       = 1'b0;
		lmg_fifo_out   = '0;
		lmg_fifo_empty = 1'b1;
		delay          = 0;
	end

	always @(posedge clk) begin
		if (reset) begin
			lmg_done <= 1'b0;
			delay    <= 0;
		end else if (lmg_reset) begin
			lmg_done <= 1'b0; // generator restarts
			delay    <= 3;
		end else if (delay != 0) begin
			delay <= delay - 1;
			if (delay == 1) begin
				lmg_done <= 1'b1; // generation finished
			end
		end
		if (lmg_read && groups.size() != 0) begin
			lmg_fifo_out <= groups.pop_front(); // held until the next read
		end
		lmg_fifo_empty <= (groups.size() == 0); // size after any pop
	end

endmodule

// ==== design/search_ctrl_top.sv ====
`timescale 1ns/1ps
`include "search_ctrl_consts.svh"

module search_ctrl_top (
	input  logic                          clk,
	input  logic                          reset,
	input  search_ctrl_pkg::ram_addr_t    slave_address,
	input  logic                          slave_read,
	input  logic                          slave_write,
	input  search_ctrl_pkg::word_t        slave_writedata,
	output search_ctrl_pkg::word_t        slave_readdata,
	output logic                          lmg_reset,
	output logic                          lmg_read,
	output search_ctrl_pkg::board_state_t board_state,
	input  logic                          lmg_done,
	input  search_ctrl_pkg::move_group_t  lmg_fifo_out,
	input  logic                          lmg_fifo_empty
);

	logic                         is_reg; // address hits the mailbox
	logic                         start, done_set;
	logic                         group_load, count_clear, group_done;
	search_ctrl_pkg::word_t       reg_rdata, reg_rdata_q, ram_rdata;
	search_ctrl_pkg::move_count_t move_count;
	logic                         rd_valid, rd_is_reg; // read pipeline
	logic                         unp_we, seq_we, eng_we, ram_we;
	search_ctrl_pkg::ram_addr_t   unp_addr, seq_addr, eng_addr, ram_wr_addr;
	search_ctrl_pkg::word_t       unp_data, seq_data, eng_data, ram_wdata;

	assign is_reg = (slave_address < `SC_NUM_REGS);

	mailbox_regs u_mailbox (
		.clk(clk), .reset(reset),
		.host_we(slave_write && is_reg),
		.host_index(slave_address[`SC_REG_INDEX_BITS-1:0]),
		.host_wdata(slave_writedata), .done_set(done_set),
		.reg_rdata(reg_rdata), .start(start), .board_state(board_state)
	);

	search_sequencer u_seq (
		.clk(clk), .reset(reset), .start(start), .lmg_done(lmg_done),
		.lmg_fifo_empty(lmg_fifo_empty), .group_done(group_done), .move_count(move_count),
		.lmg_reset(lmg_reset), .lmg_read(lmg_read), .group_load(group_load),
		.count_clear(count_clear), .wr_en(seq_we), .wr_addr(seq_addr),
		.wr_data(seq_data), .done_set(done_set)
	);

	move_unpacker u_unpack (
		.clk(clk), .reset(reset), .group(lmg_fifo_out), .group_load(group_load),
		.count_clear(count_clear), .wr_en(unp_we), .wr_addr(unp_addr),
		.wr_data(unp_data), .move_count(move_count), .group_done(group_done)
	);

	// ==================== ram write port
	// engines never write in the same cycle, and beat the host
	assign eng_we      = unp_we || seq_we;
	assign eng_addr    = unp_we ? unp_addr : seq_addr;
	assign eng_data    = unp_we ? unp_data : seq_data;
	assign ram_we      = eng_we || (slave_write && !is_reg);
	assign ram_wr_addr = eng_we ? eng_addr : slave_address;
	assign ram_wdata   = eng_we ? eng_data : slave_writedata;

	move_ram u_ram (
		.clk(clk), .we(ram_we), .wr_addr(ram_wr_addr), .wdata(ram_wdata),
		.rd_addr(slave_address), .rdata(ram_rdata)
	);

	// ==================== read path
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= slave_read;
		end
		rd_is_reg   <= is_reg;
		reg_rdata_q <= reg_rdata; // register value as of the read cycle
	end

	assign slave_readdata = !rd_valid ? '0 : (rd_is_reg ? reg_rdata_q : ram_rdata);

endmodule

// ==== design/search_sequencer.sv ====
`timescale 1ns/1ps
`include "search_ctrl_consts.svh"

module search_sequencer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic                         lmg_done,
	input  logic                         lmg_fifo_empty,
	input  logic                         group_done,
	input  search_ctrl_pkg::move_count_t move_count,
	output logic                         lmg_reset,
	output logic                         lmg_read,
	output logic                         group_load,
	output logic                         count_clear,
	output logic                         wr_en,
	output search_ctrl_pkg::ram_addr_t   wr_addr,
	output search_ctrl_pkg::word_t       wr_data,
	output logic                         done_set
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_GEN_RESET,  // second generator reset cycle
		S_WAIT_DONE,
		S_READ,       // fifo read pulse
		S_UNPACK,     // unpacker busy with a group
		S_WRITE_COUNT,
		S_WRITE_TERM
	} state_t;

	state_t state, state_nxt;
	logic   start_q;
	logic   start_edge;

	assign start_edge = start && !start_q; // start just went high

	// ==================== fsm
	always_comb begin
		state_nxt = state;
		case (state)
			S_GEN_RESET: state_nxt = S_WAIT_DONE;
			S_WAIT_DONE: if (lmg_done) state_nxt = S_READ;
			S_READ: state_nxt = S_UNPACK; // group shows up next cycle
			S_UNPACK: begin
				if (group_done) begin
					state_nxt = lmg_fifo_empty ? S_WRITE_COUNT : S_READ;
				end
			end
			S_WRITE_COUNT: state_nxt = S_WRITE_TERM;
			S_WRITE_TERM: state_nxt = S_IDLE;
			default: state_nxt = S_IDLE;
		endcase
		if (!start) begin
			state_nxt = S_IDLE; // abort on start low
		end else if (start_edge) begin
			state_nxt = S_GEN_RESET; // restart from any state
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= S_IDLE;
			start_q    <= 1'b0;
			group_load <= 1'b0;
		end else begin
			state      <= state_nxt;
			start_q    <= start;
			group_load <= (state == S_READ) && start; // cycle the group is presented
		end
	end

	// ==================== generator side
	assign lmg_reset   = start_edge || (state == S_GEN_RESET); // two cycles
	assign lmg_read    = (state == S_READ);
	assign count_clear = start_edge;

	// ==================== summary writes
	always_comb begin
		wr_en    = 1'b0;
		wr_addr  = search_ctrl_pkg::ram_addr_t'(`SC_COUNT_ADDR);
		wr_data  = '0;
		done_set = 1'b0;
		case (state)
			S_WRITE_COUNT: begin
				wr_en   = 1'b1;
				wr_data = search_ctrl_pkg::word_t'(move_count); // count at 16
			end
			S_WRITE_TERM: begin
				wr_en    = 1'b1; // zero after the last move
				wr_addr  = search_ctrl_pkg::ram_addr_t'(`SC_LIST_BASE + move_count);
				done_set = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== design/move_unpacker.sv ====
`timescale 1ns/1ps
`include "search_ctrl_consts.svh"

module move_unpacker (
	input  logic                         clk,
	input  logic                         reset,
	input  search_ctrl_pkg::move_group_t group,
	input  logic                         group_load, // group valid on lmg_fifo_out
	input  logic                         count_clear, // new search
	output logic                         wr_en,
	output search_ctrl_pkg::ram_addr_t   wr_addr,
	output search_ctrl_pkg::word_t       wr_data,
	output search_ctrl_pkg::move_count_t move_count,
	output logic                         group_done
);

	localparam int SLOT_IDX_BITS = $clog2(`SC_SLOTS);

	search_ctrl_pkg::move_group_t group_q; // held copy of the fifo word
	logic                         active;  // walking slots
	logic [SLOT_IDX_BITS-1:0]     slot_idx;
	logic [`SC_SLOT_BITS-1:0]     cur_slot;
	search_ctrl_pkg::move_t       cur_move;
	logic                         cur_invalid;

	// ==================== capture
	always_ff @(posedge clk) begin
		if (group_load) begin
			group_q <= group;
		end
	end

	// ==================== slot walk
	always_ff @(posedge clk) begin
		if (reset) begin
			active   <= 1'b0;
			slot_idx <= '0;
		end else if (group_load) begin
			active   <= 1'b1;
			slot_idx <= '0; // slot 0 first
		end else if (active) begin
			slot_idx <= slot_idx + 1'b1;
			if (group_done) begin
				active <= 1'b0; // last slot seen
			end
		end
	end

	// current slot split into flag and move
	assign cur_slot    = group_q[slot_idx*`SC_SLOT_BITS +: `SC_SLOT_BITS];
	assign cur_invalid = cur_slot[`SC_SLOT_BITS-1]; // top bit marks an empty slot
	assign cur_move    = cur_slot[`SC_MOVE_BITS-1:0];

	// ==================== move count
	always_ff @(posedge clk) begin
		if (reset) begin
			move_count <= '0;
		end else if (count_clear) begin
			move_count <= '0;
		end else if (wr_en) begin
			move_count <= move_count + 1'b1; // one per stored move
		end
	end

	// ==================== list write
	assign wr_en      = active && !cur_invalid;
	assign wr_addr    = search_ctrl_pkg::ram_addr_t'(`SC_LIST_BASE + move_count);
	assign wr_data    = search_ctrl_pkg::word_t'(cur_move); // zero extended
	assign group_done = active && (slot_idx == SLOT_IDX_BITS'(`SC_SLOTS - 1));

endmodule

// ==== design/move_ram.sv ====
`timescale 1ns/1ps
`include "search_ctrl_consts.svh"

module move_ram (
	input  logic                       clk,
	input  logic                       we,
	input  search_ctrl_pkg::ram_addr_t wr_addr,
	input  search_ctrl_pkg::word_t     wdata,
	input  search_ctrl_pkg::ram_addr_t rd_addr,
	output search_ctrl_pkg::word_t     rdata
);

	localparam int DEPTH = 1 << `SC_ADDR_WIDTH; // full address space

	search_ctrl_pkg::word_t mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wdata;
		end
	end

	// read port with one cycle latency
	always_ff @(posedge clk) begin
		rdata <= mem[rd_addr]; // old data on same-address collision
	end

endmodule

// ==== design/mailbox_regs.sv ====
`timescale 1ns/1ps
`include "search_ctrl_consts.svh"

module mailbox_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        host_we,
	input  search_ctrl_pkg::reg_index_t host_index,
	input  search_ctrl_pkg::word_t      host_wdata,
	input  logic                        done_set, // pulse from sequencer
	output search_ctrl_pkg::word_t      reg_rdata,
	output logic                        start,
	output search_ctrl_pkg::board_state_t board_state
);

	search_ctrl_pkg::word_t regs [`SC_NUM_REGS]; // reg 0 is control

	// ==================== register file
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `SC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (host_we) begin
				regs[host_index] <= host_wdata; // host write lands on this edge
			end
			// done follows start and overrides the host word
			if (!regs[0][`SC_START_BIT]) begin
				regs[0][`SC_DONE_BIT] <= 1'b0; // held low while idle
			end else if (done_set) begin
				regs[0][`SC_DONE_BIT] <= 1'b1; // search finished
			end
		end
	end

	// ==================== outputs
	assign reg_rdata = regs[host_index]; // current value that the top registers
	assign start = regs[0][`SC_START_BIT];

	// pack board words with the lowest register in the lowest word
	always_comb begin
		for (int i = 0; i < `SC_BOARD_REGS; i++) begin
			board_state[i*`SC_DATA_WIDTH +: `SC_DATA_WIDTH] = regs[`SC_BOARD_FIRST_REG + i];
		end
	end

endmodule

// ==== design/search_ctrl_pkg.sv ====
`include "search_ctrl_consts.svh"

package search_ctrl_pkg;

	// host bus / ram data word
	typedef logic [`SC_DATA_WIDTH-1:0] word_t;
	typedef logic [`SC_ADDR_WIDTH-1:0] ram_addr_t;

	// index into the mailbox block
	typedef logic [`SC_REG_INDEX_BITS-1:0] reg_index_t;

	// one encoded move without the flag
	typedef logic [`SC_MOVE_BITS-1:0] move_t;

	// fifo output with slot 0 in the low bits
	typedef logic [`SC_SLOTS*`SC_SLOT_BITS-1:0] move_group_t;

	// reg 9 in the top word and reg 2 in the bottom
	typedef logic [`SC_BOARD_REGS*`SC_DATA_WIDTH-1:0] board_state_t;

	typedef logic [`SC_COUNT_WIDTH-1:0] move_count_t;

endpackage

// ==== design/search_ctrl_consts.svh ====
`ifndef SEARCH_CTRL_CONSTS_SVH
`define SEARCH_CTRL_CONSTS_SVH

// ==================== bus and ram
`define SC_DATA_WIDTH 32 // host bus and ram word
`define SC_ADDR_WIDTH 15 // slave and ram address over 32768 words

// ==================== mailbox
`define SC_NUM_REGS 16 // addresses below this hit the registers
`define SC_REG_INDEX_BITS 4
`define SC_START_BIT 0 // control register bits
`define SC_DONE_BIT 1
`define SC_BOARD_FIRST_REG 2 // board state in regs 2..9
`define SC_BOARD_REGS 8

// ==================== generator fifo
`define SC_SLOTS 8 // move slots per fifo group
`define SC_MOVE_BITS 18
`define SC_SLOT_BITS 19 // move plus invalid flag on top

// ==================== move list layout
`define SC_COUNT_ADDR 16 // summary word
`define SC_LIST_BASE 17 // first move of the list
`define SC_COUNT_WIDTH 8

`endif
